// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator, runs it and checks the log.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 -f sources.f --top-module DecodeUnitTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/VDecodeUnitTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
  exit 0
fi
echo "Pass message not found in $LOG"
exit 1

// File: source/DecodeStage.sv
`timescale 1ns/1ps

module DecodeStage (
  input  logic                            clk,
  input  logic                            rstN,
  input  DecodeTypes::FetchStagePipeReg   fetchReg,
  input  DecodeTypes::RegAddr             rdAddr,
  input  DecodeTypes::BasicData           imm,
  input  DecodeTypes::OpInfo              opInfo,
  input  DecodeTypes::BasicData           rs1Data,
  input  DecodeTypes::BasicData           rs2Data,
  input  DecodeTypes::BypassCtrl          op1BypassCtrl,
  input  DecodeTypes::BypassCtrl          op2BypassCtrl,
  input  logic                            dataHazard,
  input  logic                            branchMiss,
  output DecodeTypes::ExecuteStagePipeReg execReg
);

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      execReg <= '0;
    end else if (dataHazard || branchMiss) begin
      // Bubble.
      execReg <= '0;
    end else begin
      execReg.pc <= fetchReg.pc;
      execReg.rs1Data <= rs1Data;
      execReg.rs2Data <= rs2Data;
      execReg.rdAddr <= rdAddr;
      execReg.op1BypassCtrl <= op1BypassCtrl;
      execReg.op2BypassCtrl <= op2BypassCtrl;
      execReg.imm <= imm;
      execReg.opInfo <= opInfo;
      execReg.isBranchTakenPredicted <= fetchReg.isBranchTakenPredicted;
      execReg.isNextPcPredicted <= fetchReg.isNextPcPredicted;
      execReg.predictedNextPC <= fetchReg.predictedNextPC;
    end
  end

  // Wrong-path instruction must never reach writeback.
  assert property (@(posedge clk) disable iff (!rstN)
    branchMiss |=> (execReg.opInfo.rdWrite == 1'b0))
    else $error("register write survived a branch miss");

endmodule

// File: source/DecodeTypes.sv
package DecodeTypes;

  typedef logic [4:0]  RegAddr;
  typedef logic [31:0] BasicData;
  typedef logic [31:0] Inst;
  typedef logic [31:0] Pc;
  typedef logic [6:0]  Opcode;

  localparam int     REG_COUNT = 32;
  localparam RegAddr ZERO_REG  = 5'd0;

  // RV32I major opcodes handled by the decoder.
  localparam Opcode OPCODE_OP     = 7'b0110011;
  localparam Opcode OPCODE_OP_IMM = 7'b0010011;
  localparam Opcode OPCODE_LUI    = 7'b0110111;
  localparam Opcode OPCODE_AUIPC  = 7'b0010111;
  localparam Opcode OPCODE_JAL    = 7'b1101111;
  localparam Opcode OPCODE_JALR   = 7'b1100111;
  localparam Opcode OPCODE_BRANCH = 7'b1100011;
  localparam Opcode OPCODE_LOAD   = 7'b0000011;
  localparam Opcode OPCODE_STORE  = 7'b0100011;

  typedef enum logic [3:0] {
    ALU_NONE, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS2
  } AluCode;

  typedef enum logic [1:0] {
    OP_TYPE_NONE, OP_TYPE_REG, OP_TYPE_IMM, OP_TYPE_PC
  } OpType;

  typedef enum logic [1:0] {
    BYPASS_NONE, BYPASS_EXEC, BYPASS_MEM
  } BypassCtrl;

  // All zero is a bubble.
  typedef struct packed {
    AluCode     aluOp;
    OpType      aluOp1Type;
    OpType      aluOp2Type;
    logic       usesRs1;
    logic       usesRs2;
    logic       rdWrite;
    logic       isLoad;
    logic       isStore;
    logic       isBranch;
    logic       isJump;
    logic [2:0] funct3;
  } OpInfo;

  typedef struct packed {
    Pc    pc;
    Inst  inst;
    logic isBranchTakenPredicted;
    logic isNextPcPredicted;
    Pc    predictedNextPC;
  } FetchStagePipeReg;

  typedef struct packed {
    Pc         pc;
    BasicData  rs1Data;
    BasicData  rs2Data;
    RegAddr    rdAddr;
    BypassCtrl op1BypassCtrl;
    BypassCtrl op2BypassCtrl;
    BasicData  imm;
    OpInfo     opInfo;
    logic      isBranchTakenPredicted;
    logic      isNextPcPredicted;
    Pc         predictedNextPC;
  } ExecuteStagePipeReg;

  typedef struct packed {
    logic     en;
    RegAddr   addr;
    BasicData data;
  } WriteBack;

endpackage

// File: source/DecodeUnit.sv
`timescale 1ns/1ps

module DecodeUnit (
  input  logic                            clk,
  input  logic                            rstN,
  input  DecodeTypes::FetchStagePipeReg   fetchReg,
  input  DecodeTypes::WriteBack           writeBack,
  input  DecodeTypes::RegAddr             memRdAddr,
  input  logic                            memRdWrite,
  input  logic                            branchMiss,
  output DecodeTypes::ExecuteStagePipeReg execReg,
  output logic                            stall
);

  DecodeTypes::RegAddr    rs1Addr;
  DecodeTypes::RegAddr    rs2Addr;
  DecodeTypes::RegAddr    rdAddr;
  DecodeTypes::BasicData  imm;
  DecodeTypes::OpInfo     opInfo;
  DecodeTypes::BasicData  rs1Data;
  DecodeTypes::BasicData  rs2Data;
  DecodeTypes::BypassCtrl op1BypassCtrl;
  DecodeTypes::BypassCtrl op2BypassCtrl;
  logic                   dataHazard;

  Decoder u_decoder (
    .inst    (fetchReg.inst),
    .rs1Addr (rs1Addr),
    .rs2Addr (rs2Addr),
    .rdAddr  (rdAddr),
    .imm     (imm),
    .opInfo  (opInfo)
  );

  RegisterFile u_registerFile (.*);

  // Execute-stage destination comes back from the pipeline register.
  HazardUnit u_hazardUnit (
    .execRdAddr (execReg.rdAddr),
    .execOpInfo (execReg.opInfo),
    .*
  );

  DecodeStage u_decodeStage (.*);

  assign stall = dataHazard;

endmodule

// File: source/Decoder.sv
`timescale 1ns/1ps

module Decoder (
  input  DecodeTypes::Inst      inst,
  output DecodeTypes::RegAddr   rs1Addr,
  output DecodeTypes::RegAddr   rs2Addr,
  output DecodeTypes::RegAddr   rdAddr,
  output DecodeTypes::BasicData imm,
  output DecodeTypes::OpInfo    opInfo
);

  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;
  DecodeTypes::BasicData immI;
  DecodeTypes::BasicData immS;
  DecodeTypes::BasicData immB;
  DecodeTypes::BasicData immU;
  DecodeTypes::BasicData immJ;

  // Shared by OP and OP-IMM; alt selects SUB or SRA.
  function automatic DecodeTypes::AluCode aluFromFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000: begin
        if (alt) return DecodeTypes::ALU_SUB;
        return DecodeTypes::ALU_ADD;
      end
      3'b001: return DecodeTypes::ALU_SLL;
      3'b010: return DecodeTypes::ALU_SLT;
      3'b011: return DecodeTypes::ALU_SLTU;
      3'b100: return DecodeTypes::ALU_XOR;
      3'b101: begin
        if (alt) return DecodeTypes::ALU_SRA;
        return DecodeTypes::ALU_SRL;
      end
      3'b110: return DecodeTypes::ALU_OR;
      default: return DecodeTypes::ALU_AND;
    endcase
  endfunction

  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign rs1Addr = inst[19:15];
  assign rs2Addr = inst[24:20];
  assign rdAddr  = inst[11:7];

  assign immI = {{20{inst[31]}}, inst[31:20]};
  assign immS = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign immB = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign immU = {inst[31:12], 12'b0};
  assign immJ = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    opInfo = '0;
    imm = '0;
    legal = 1'b1;
    opInfo.funct3 = funct3;
    case (inst[6:0])
      DecodeTypes::OPCODE_OP: begin
        legal = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        opInfo.aluOp = aluFromFunct(funct3, funct7[5]);
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_REG;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_REG;
        opInfo.usesRs1 = 1'b1;
        opInfo.usesRs2 = 1'b1;
        opInfo.rdWrite = 1'b1;
      end
      DecodeTypes::OPCODE_OP_IMM: begin
        // Shift immediates reuse funct7 as a selector.
        legal = (funct3 != 3'b001 || funct7 == 7'b0000000) &&
                (funct3 != 3'b101 || {funct7[6], funct7[4:0]} == 6'b0);
        opInfo.aluOp = aluFromFunct(funct3, funct3 == 3'b101 && funct7[5]);
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_REG;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.usesRs1 = 1'b1;
        opInfo.rdWrite = 1'b1;
        imm = immI;
      end
      DecodeTypes::OPCODE_LUI: begin
        opInfo.aluOp = DecodeTypes::ALU_PASS2;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.rdWrite = 1'b1;
        imm = immU;
      end
      DecodeTypes::OPCODE_AUIPC: begin
        opInfo.aluOp = DecodeTypes::ALU_ADD;
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_PC;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.rdWrite = 1'b1;
        imm = immU;
      end
      DecodeTypes::OPCODE_JAL: begin
        opInfo.aluOp = DecodeTypes::ALU_ADD;
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_PC;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.rdWrite = 1'b1;
        opInfo.isJump = 1'b1;
        imm = immJ;
      end
      DecodeTypes::OPCODE_JALR: begin
        legal = funct3 == 3'b000;
        opInfo.aluOp = DecodeTypes::ALU_ADD;
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_REG;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.usesRs1 = 1'b1;
        opInfo.rdWrite = 1'b1;
        opInfo.isJump = 1'b1;
        imm = immI;
      end
      DecodeTypes::OPCODE_BRANCH: begin
        legal = funct3[2:1] != 2'b01;
        opInfo.aluOp = DecodeTypes::ALU_SUB;
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_REG;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_REG;
        opInfo.usesRs1 = 1'b1;
        opInfo.usesRs2 = 1'b1;
        opInfo.isBranch = 1'b1;
        imm = immB;
      end
      DecodeTypes::OPCODE_LOAD: begin
        legal = funct3 != 3'b011 && funct3[2:1] != 2'b11;
        opInfo.aluOp = DecodeTypes::ALU_ADD;
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_REG;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.usesRs1 = 1'b1;
        opInfo.rdWrite = 1'b1;
        opInfo.isLoad = 1'b1;
        imm = immI;
      end
      DecodeTypes::OPCODE_STORE: begin
        legal = !funct3[2] && funct3[1:0] != 2'b11;
        opInfo.aluOp = DecodeTypes::ALU_ADD;
        opInfo.aluOp1Type = DecodeTypes::OP_TYPE_REG;
        opInfo.aluOp2Type = DecodeTypes::OP_TYPE_IMM;
        opInfo.usesRs1 = 1'b1;
        opInfo.usesRs2 = 1'b1;
        opInfo.isStore = 1'b1;
        imm = immS;
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      opInfo = '0;
      imm = '0;
    end
  end

endmodule

// File: source/HazardUnit.sv
`timescale 1ns/1ps

module HazardUnit (
  input  DecodeTypes::RegAddr    rs1Addr,
  input  DecodeTypes::RegAddr    rs2Addr,
  input  DecodeTypes::OpInfo     opInfo,
  input  DecodeTypes::RegAddr    execRdAddr,
  input  DecodeTypes::OpInfo     execOpInfo,
  input  DecodeTypes::RegAddr    memRdAddr,
  input  logic                   memRdWrite,
  output DecodeTypes::BypassCtrl op1BypassCtrl,
  output DecodeTypes::BypassCtrl op2BypassCtrl,
  output logic                   dataHazard
);

  logic rs1LoadMatch;
  logic rs2LoadMatch;

  // Youngest producer wins, so execute is checked before memory.
  function automatic DecodeTypes::BypassCtrl selectBypass(input DecodeTypes::RegAddr src,
                                                          input logic used);
    if (!used || src == DecodeTypes::ZERO_REG) begin
      return DecodeTypes::BYPASS_NONE;
    end
    if (execOpInfo.rdWrite && execRdAddr == src) begin
      return DecodeTypes::BYPASS_EXEC;
    end
    if (memRdWrite && memRdAddr == src) begin
      return DecodeTypes::BYPASS_MEM;
    end
    return DecodeTypes::BYPASS_NONE;
  endfunction

  always_comb begin
    op1BypassCtrl = selectBypass(rs1Addr, opInfo.usesRs1);
    op2BypassCtrl = selectBypass(rs2Addr, opInfo.usesRs2);
  end

  // Load data is not ready until the memory stage.
  assign rs1LoadMatch = opInfo.usesRs1 && rs1Addr == execRdAddr;
  assign rs2LoadMatch = opInfo.usesRs2 && rs2Addr == execRdAddr;
  assign dataHazard = execOpInfo.isLoad && execRdAddr != DecodeTypes::ZERO_REG &&
                      (rs1LoadMatch || rs2LoadMatch);

  // A stalling load must also be seen as an execute-stage producer.
  always_comb begin
    if (dataHazard) begin
      assert (execOpInfo.isLoad &&
              (op1BypassCtrl == DecodeTypes::BYPASS_EXEC ||
               op2BypassCtrl == DecodeTypes::BYPASS_EXEC))
        else $error("load-use hazard without an execute bypass match");
    end
  end

endmodule

// File: source/RegisterFile.sv
`timescale 1ns/1ps

module RegisterFile (
  input  logic                  clk,
  input  logic                  rstN,
  input  DecodeTypes::RegAddr   rs1Addr,
  input  DecodeTypes::RegAddr   rs2Addr,
  input  DecodeTypes::WriteBack writeBack,
  output DecodeTypes::BasicData rs1Data,
  output DecodeTypes::BasicData rs2Data
);

  DecodeTypes::BasicData regs [DecodeTypes::REG_COUNT];

  // x0 is hardwired; a write in flight bypasses the array.
  function automatic DecodeTypes::BasicData readReg(input DecodeTypes::RegAddr addr);
    if (addr == DecodeTypes::ZERO_REG) begin
      return '0;
    end
    if (writeBack.en && writeBack.addr == addr) begin
      return writeBack.data;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      regs <= '{default: '0};
    end else if (writeBack.en && writeBack.addr != DecodeTypes::ZERO_REG) begin
      regs[writeBack.addr] <= writeBack.data;
    end
  end

  always_comb begin
    rs1Data = readReg(rs1Addr);
    rs2Data = readReg(rs2Addr);
  end

  // x0 storage never changes, even when written.
  assert property (@(posedge clk) disable iff (!rstN)
    regs[DecodeTypes::ZERO_REG] == '0)
    else $error("x0 storage was overwritten");

endmodule

// File: sources.f
source/DecodeTypes.sv
source/Decoder.sv
source/RegisterFile.sv
source/HazardUnit.sv
source/DecodeStage.sv
source/DecodeUnit.sv
test/DecodeUnitTb.sv

// File: test/DecodeUnitTb.sv
`timescale 1ns/1ps

module DecodeUnitTb;

  localparam int CLK_PERIOD = 10;
  localparam int RESET_CYCLES = 8;

  // One line of the cases file, inputs first and then expected results.
  typedef struct packed {
    DecodeTypes::Inst      inst;
    DecodeTypes::Pc        pc;
    logic                  wbEn;
    DecodeTypes::RegAddr   wbAddr;
    DecodeTypes::BasicData wbData;
    DecodeTypes::RegAddr   memRdAddr;
    logic                  memRdWrite;
    logic                  branchMiss;
    logic                  expStall;
    DecodeTypes::RegAddr   expRdAddr;
    DecodeTypes::BasicData expImm;
    DecodeTypes::BasicData expRs1;
    DecodeTypes::BasicData expRs2;
    logic [1:0]            expOp1;
    logic [1:0]            expOp2;
    logic                  expRdWrite;
  } TestCase;

  logic                            clk;
  logic                            rstN;
  DecodeTypes::FetchStagePipeReg   fetchReg;
  DecodeTypes::WriteBack           writeBack;
  DecodeTypes::RegAddr             memRdAddr;
  logic                            memRdWrite;
  logic                            branchMiss;
  DecodeTypes::ExecuteStagePipeReg execReg;
  logic                            stall;

  TestCase cases[$];
  string   names[$];
  bit      loaded;
  int      passCount;
  int      failCount;
  int      caseErrors;

  DecodeUnit u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic loadCases();
    int    fd;
    int    count;
    string line;
    string name;
    TestCase tc;
    logic [31:0] inst, pc, wbData, imm, rs1, rs2;
    logic [4:0]  wbAddr, memAddr, rd;
    logic [1:0]  op1, op2;
    logic        wbEn, memWr, miss, expStall, rdWrite;
    fd = $fopen("test/decode_cases.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the cases file test/decode_cases.txt");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line.getc(0) == "#") continue;
      count = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
                      inst, pc, wbEn, wbAddr, wbData, memAddr, memWr, miss,
                      expStall, rd, imm, rs1, rs2, op1, op2, rdWrite);
      if (count != 17) begin
        $display("Skipping a malformed line in the cases file: %s", line);
        failCount++;
        continue;
      end
      tc = '{inst, pc, wbEn, wbAddr, wbData, memAddr, memWr, miss,
             expStall, rd, imm, rs1, rs2, op1, op2, rdWrite};
      cases.push_back(tc);
      names.push_back(name);
    end
    $fclose(fd);
  endtask

  task automatic driveInputs(input TestCase tc);
    fetchReg.pc <= tc.pc;
    fetchReg.inst <= tc.inst;
    // Prediction fields follow the pc so each case carries its own values.
    fetchReg.isBranchTakenPredicted <= tc.pc[2];
    fetchReg.isNextPcPredicted <= tc.pc[3];
    fetchReg.predictedNextPC <= tc.pc + 32'd4;
    writeBack.en <= tc.wbEn;
    writeBack.addr <= tc.wbAddr;
    writeBack.data <= tc.wbData;
    memRdAddr <= tc.memRdAddr;
    memRdWrite <= tc.memRdWrite;
    branchMiss <= tc.branchMiss;
  endtask

  task automatic checkField(input string name, input string field,
                            input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("ERROR %s %s: expected %h, actual %h", name, field, expected, actual);
      caseErrors++;
    end
  endtask

  task automatic checkExecute(input string name, input TestCase tc);
    logic bubble;
    // A stalled or squashed slot leaves an all-zero register.
    bubble = tc.expStall || tc.branchMiss;
    checkField(name, "rdAddr", 32'(tc.expRdAddr), 32'(execReg.rdAddr));
    checkField(name, "imm", tc.expImm, execReg.imm);
    checkField(name, "rs1Data", tc.expRs1, execReg.rs1Data);
    checkField(name, "rs2Data", tc.expRs2, execReg.rs2Data);
    checkField(name, "op1Bypass", 32'(tc.expOp1), 32'(execReg.op1BypassCtrl));
    checkField(name, "op2Bypass", 32'(tc.expOp2), 32'(execReg.op2BypassCtrl));
    checkField(name, "rdWrite", 32'(tc.expRdWrite), 32'(execReg.opInfo.rdWrite));
    checkField(name, "pc", bubble ? 32'h0 : tc.pc, execReg.pc);
    checkField(name, "predictedNextPC", bubble ? 32'h0 : tc.pc + 32'd4,
               execReg.predictedNextPC);
    checkField(name, "isBranchTakenPredicted", 32'(!bubble && tc.pc[2]),
               32'(execReg.isBranchTakenPredicted));
    checkField(name, "isNextPcPredicted", 32'(!bubble && tc.pc[3]),
               32'(execReg.isNextPcPredicted));
  endtask

  task automatic reportCase(input string name);
    if (caseErrors == 0) begin
      passCount++;
      $display("PASS %s", name);
    end else begin
      failCount++;
      $display("FAIL %s with %0d mismatches", name, caseErrors);
    end
    caseErrors = 0;
  endtask

  initial begin
    rstN = 1'b0;
    fetchReg = '0;
    writeBack = '0;
    memRdAddr = '0;
    memRdWrite = 1'b0;
    branchMiss = 1'b0;
    passCount = 0;
    failCount = 0;
    caseErrors = 0;
    loadCases();
    if (cases.size() == 0) begin
      $display("No test cases could be read, so nothing was run");
      $display("TEST FAILED");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rstN <= 1'b1;
      @(negedge clk);
      if (execReg !== '0) begin
        $display("ERROR reset execReg: expected 0, actual %h", execReg);
        caseErrors++;
      end
      checkField("reset", "stall", 32'h0, 32'(stall));
      reportCase("reset");
      // Case i is driven while case i-1 sits in the execute register.
      for (int i = 0; i <= cases.size(); i++) begin
        @(posedge clk);
        if (i < cases.size()) begin
          driveInputs(cases[i]);
        end else begin
          driveInputs('0);
        end
        @(negedge clk);
        if (i > 0) begin
          checkExecute(names[i - 1], cases[i - 1]);
          reportCase(names[i - 1]);
        end
        if (i < cases.size()) begin
          checkField(names[i], "stall", 32'(cases[i].expStall), 32'(stall));
        end
      end
      $display("Summary: %0d passed, %0d failed", passCount, failCount);
      if (failCount == 0) begin
        $display("TEST PASSED");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

  // Budget covers reset plus one cycle per case with margin.
  initial begin
    wait (loaded);
    #((cases.size() + 20) * CLK_PERIOD);
    $display("Timeout: the test run did not finish in the expected time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: test/decode_cases.txt
# name inst pc wbEn wbAddr wbData memRdAddr memRdWrite branchMiss, then expected values:
# stall rdAddr imm rs1Data rs2Data op1Bypass op2Bypass rdWrite (all hex)
addi_neg      FFB00093 00000000 0 00 00000000 00 0 0 0 01 FFFFFFFB 00000000 00000000 0 0 1
lui           12345137 00000004 0 00 00000000 00 0 0 0 02 12345000 00000000 00000000 0 0 1
sw_neg        FE532A23 00000008 0 00 00000000 00 0 0 0 14 FFFFFFF4 00000000 00000000 0 0 0
beq_back      FE2088E3 0000000C 0 00 00000000 02 1 0 0 11 FFFFFFF0 00000000 00000000 0 2 0
jal_back      801FF0EF 00000010 0 00 00000000 00 0 0 0 01 FFFFF800 00000000 00000000 0 0 1
illegal       FFFFFFFF 00000014 0 00 00000000 00 0 0 0 1F 00000000 00000000 00000000 0 0 0
wb_x3         00000013 00000018 1 03 DEADBEEF 00 0 0 0 00 00000000 00000000 00000000 0 0 1
add_read_x3   00018233 0000001C 0 00 00000000 00 0 0 0 04 00000000 DEADBEEF 00000000 0 0 1
write_through 00328333 00000020 1 05 0000CAFE 00 0 0 0 06 00000000 0000CAFE DEADBEEF 0 0 1
x0_write      000003B3 00000024 1 00 12345678 00 0 0 0 07 00000000 00000000 00000000 0 0 1
bypass_exec   00038433 00000028 0 00 00000000 00 0 0 0 08 00000000 00000000 00000000 1 0 1
bypass_mixed  008184B3 0000002C 0 00 00000000 03 1 0 0 09 00000000 DEADBEEF 00000000 2 1 1
exec_over_mem 00948533 00000030 0 00 00000000 09 1 0 0 0A 00000000 00000000 00000000 1 1 1
lw_x11        0042A583 00000034 0 00 00000000 00 0 0 0 0B 00000004 0000CAFE 00000000 0 0 1
load_use      00358633 00000038 0 00 00000000 00 0 0 1 00 00000000 00000000 00000000 0 0 0
load_use_held 00358633 00000038 0 00 00000000 0B 1 0 0 0C 00000000 00000000 DEADBEEF 2 0 1
branch_miss   00C606B3 0000003C 0 00 00000000 00 0 1 0 00 00000000 00000000 00000000 0 0 0
miss_lui      ABCDE737 00000040 0 00 00000000 00 0 1 0 00 00000000 00000000 00000000 0 0 0
after_miss    7FF08793 00000044 0 00 00000000 00 0 0 0 0F 000007FF 00000000 00000000 0 0 1
